/* common/miniAluPkg.sv */
`default_nettype none

package miniAluPkg;

	// ------------------------------------------------------------
	// Instruction format
	// ------------------------------------------------------------
	localparam int InstrWidth  = 28;
	localparam int FieldWidth  = 8; // Destination, source 1, source 0
	localparam int OpcodeWidth = InstrWidth - 3 * FieldWidth;
	localparam int LedWidth    = 8;

	// Opcode in bits [27:24]
	typedef enum logic [OpcodeWidth-1:0] {
		NOP  = 4'h0,
		STO  = 4'h1, // dest = {src1, src0}
		ADD  = 4'h2,
		INC  = 4'h3,
		BGE  = 4'h4,
		BLE  = 4'h5,
		JMP  = 4'h6,
		CALL = 4'h7,
		RET  = 4'h8,
		LED  = 4'h9,
		HLT  = 4'hA  // Stops fetch, sets halted status
	} opcodeT;

	// ------------------------------------------------------------
	// Host bus
	// ------------------------------------------------------------
	localparam int ApbAddrWidth = 12;
	localparam int ApbDataWidth = 32;

	localparam logic [ApbAddrWidth-1:0] CtrlOffset   = 12'h000; // Bit 0 run
	localparam logic [ApbAddrWidth-1:0] StatusOffset = 12'h004; // Bit 0 running, bit 1 halted
	localparam logic [ApbAddrWidth-1:0] LedOffset    = 12'h008;
	localparam logic [ApbAddrWidth-1:0] CountOffset  = 12'h00C;

	// Program word i at ProgBase + 4*i
	localparam logic [ApbAddrWidth-1:0] ProgBase     = 12'h400;

endpackage

`default_nettype wire

/* logic/registerFile.sv */
`default_nettype none

module registerFile #(
	parameter int DataWidth = 16
) (
	input  logic                              Clock,
	input  logic                              writeEnable,
	input  logic [miniAluPkg::FieldWidth-1:0] writeAddr,
	input  logic [DataWidth-1:0]              writeData,
	input  logic [miniAluPkg::FieldWidth-1:0] readAddr0,
	input  logic [miniAluPkg::FieldWidth-1:0] readAddr1,
	output logic [DataWidth-1:0]              readData0,
	output logic [DataWidth-1:0]              readData1
);
	import miniAluPkg::*;

	// One entry per address field value
	logic [DataWidth-1:0] regs [2**FieldWidth];

	always_ff @(posedge Clock)
	begin
		if (writeEnable)
			regs[writeAddr] <= writeData; // Visible to the next instruction
	end

	// Combinational reads
	assign readData0 = regs[readAddr0];
	assign readData1 = regs[readAddr1];

endmodule

`default_nettype wire

/* fetch/fetchStage.sv */
`default_nettype none

module fetchStage #(
	parameter int ProgAddrWidth = 8
) (
	input  logic                              Clock,
	input  logic                              rst,
	input  logic                              progWrite,
	input  logic [ProgAddrWidth-1:0]          progAddr,
	input  logic [miniAluPkg::InstrWidth-1:0] progData,
	input  logic                              start,
	input  logic                              redirect,
	input  logic [ProgAddrWidth-1:0]          redirectTarget,
	input  logic                              halt,
	output logic [miniAluPkg::InstrWidth-1:0] instr,
	output logic                              instrValid,
	output logic [ProgAddrWidth-1:0]          returnAddr
);
	import miniAluPkg::*;

	logic [InstrWidth-1:0]    progMem [2**ProgAddrWidth];
	logic [ProgAddrWidth-1:0] pc;
	logic                     fetching;
	logic [InstrWidth-1:0]    nextInstr;
	logic                     advance;

	assign nextInstr = progMem[pc];
	assign advance   = fetching && !redirect && !halt; // Nothing is kept behind a branch

	// Program load from the host, only while stopped
	always_ff @(posedge Clock)
	begin
		if (progWrite)
			progMem[progAddr] <= progData;
	end

	// ------------------------------------------------------------
	// Program counter and valid flag
	// ------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			pc         <= '0;
			fetching   <= 1'b0;
			instrValid <= 1'b0;
		end
		else if (start)
		begin
			pc         <= '0;
			fetching   <= 1'b1;
			instrValid <= 1'b0;
		end
		else if (halt)
		begin
			fetching   <= 1'b0; // Instruction behind HLT is dropped
			instrValid <= 1'b0;
		end
		else if (redirect)
		begin
			pc         <= redirectTarget;
			instrValid <= 1'b0; // One bubble
		end
		else if (fetching)
		begin
			pc         <= pc + 1'b1;
			instrValid <= 1'b1;
		end
	end

	// Fetch register and return buffer
	always_ff @(posedge Clock)
	begin
		if (advance)
		begin
			instr <= nextInstr;
			// Address after the CALL, used by the next RET
			if (opcodeT'(nextInstr[InstrWidth-1 -: OpcodeWidth]) == CALL)
				returnAddr <= pc + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`default_nettype none

module executeStage #(
	parameter int DataWidth     = 16,
	parameter int ProgAddrWidth = 8
) (
	input  logic                              Clock,
	input  logic                              rst,
	input  logic [miniAluPkg::InstrWidth-1:0] instr,
	input  logic                              instrValid,
	input  logic [ProgAddrWidth-1:0]          returnAddr,
	input  logic [DataWidth-1:0]              readData0,
	input  logic [DataWidth-1:0]              readData1,
	output logic                              redirect,
	output logic [ProgAddrWidth-1:0]          redirectTarget,
	output logic                              halt,
	output logic [miniAluPkg::FieldWidth-1:0] readAddr0,
	output logic [miniAluPkg::FieldWidth-1:0] readAddr1,
	output logic                              writeEnable,
	output logic [miniAluPkg::FieldWidth-1:0] writeAddr,
	output logic [DataWidth-1:0]              writeData,
	output logic [miniAluPkg::LedWidth-1:0]   led,
	output logic                              halted,
	output logic [DataWidth-1:0]              retired
);
	import miniAluPkg::*;

	opcodeT                opcode;
	logic [FieldWidth-1:0] destField;
	logic [FieldWidth-1:0] src1Field;
	logic [FieldWidth-1:0] src0Field;
	logic [DataWidth-1:0]  immediate;
	logic                  useReturn;
	logic                  ledEnable;
	logic                  runDone; // Last retired instruction was HLT

	assign opcode    = opcodeT'(instr[InstrWidth-1 -: OpcodeWidth]);
	assign destField = instr[3*FieldWidth-1 -: FieldWidth];
	assign src1Field = instr[2*FieldWidth-1 -: FieldWidth];
	assign src0Field = instr[FieldWidth-1:0];
	assign immediate = DataWidth'({src1Field, src0Field});

	assign readAddr0 = src0Field;
	assign readAddr1 = src1Field;
	assign writeAddr = destField;

	assign redirectTarget = useReturn ? returnAddr : ProgAddrWidth'(destField);

	// ------------------------------------------------------------
	// Decode, ALU and branch decision
	// ------------------------------------------------------------
	always_comb
	begin
		writeEnable = 1'b0;
		writeData   = '0;
		redirect    = 1'b0;
		useReturn   = 1'b0;
		ledEnable   = 1'b0;
		halt        = 1'b0;
		if (instrValid)
		begin
			case (opcode)
				STO:
				begin
					writeEnable = 1'b1;
					writeData   = immediate;
				end
				ADD:
				begin
					writeEnable = 1'b1;
					writeData   = readData1 + readData0;
				end
				INC:
				begin
					writeEnable = 1'b1;
					writeData   = readData1 + 1'b1;
				end
				BGE:       redirect = (readData1 >= readData0); // Unsigned
				BLE:       redirect = (readData1 <= readData0);
				JMP, CALL: redirect = 1'b1;
				RET:
				begin
					redirect  = 1'b1;
					useReturn = 1'b1;
				end
				LED:       ledEnable = 1'b1;
				HLT:       halt = 1'b1;
				default:   ; // NOP and unknown opcodes
			endcase
		end
	end

	// LED latch, halt pulse and retire count
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			led     <= '0;
			halted  <= 1'b0;
			runDone <= 1'b0;
			retired <= '0;
		end
		else
		begin
			halted <= halt;
			if (ledEnable)
				led <= readData1[LedWidth-1:0];
			if (instrValid)
			begin
				// First instruction after a HLT opens a new count
				retired <= runDone ? DataWidth'(1) : retired + 1'b1;
				runDone <= halt;
			end
		end
	end

	// Only control transfers redirect, and they never write back
	assert property (@(posedge Clock) disable iff (rst) !(writeEnable && redirect))
		else $error("writeEnable and redirect high together");

	// Fetch must drop the instruction behind HLT
	assert property (@(posedge Clock) disable iff (rst) halt |=> !instrValid)
		else $error("instruction executed after HLT");

endmodule

`default_nettype wire

/* logic/apbHostPort.sv */
`default_nettype none

module apbHostPort #(
	parameter int DataWidth     = 16,
	parameter int ProgAddrWidth = 8
) (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [miniAluPkg::ApbAddrWidth-1:0] paddr,
	input  logic [miniAluPkg::ApbDataWidth-1:0] pwdata,
	input  logic                                halted,
	input  logic [miniAluPkg::LedWidth-1:0]     led,
	input  logic [DataWidth-1:0]                retired,
	output logic [miniAluPkg::ApbDataWidth-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                progWrite,
	output logic [ProgAddrWidth-1:0]            progAddr,
	output logic [miniAluPkg::InstrWidth-1:0]   progData,
	output logic                                start
);
	import miniAluPkg::*;

	localparam int ProgEnd = int'(ProgBase) + (4 << ProgAddrWidth);

	logic access;
	logic hitCtrl;
	logic hitStatus;
	logic hitLed;
	logic hitCount;
	logic hitProg;
	logic writeOk;
	logic run;
	logic haltedFlag;

	// ------------------------------------------------------------
	// Address decode and error checks
	// ------------------------------------------------------------
	assign access    = psel && penable;
	assign hitCtrl   = (paddr == CtrlOffset);
	assign hitStatus = (paddr == StatusOffset);
	assign hitLed    = (paddr == LedOffset);
	assign hitCount  = (paddr == CountOffset);
	assign hitProg   = (paddr >= ProgBase) && (paddr < ProgEnd) && (paddr[1:0] == 2'b00);

	assign pready  = 1'b1; // Zero wait states
	assign pslverr = access && (!(hitCtrl || hitStatus || hitLed || hitCount || hitProg)
		|| (pwrite && (hitStatus || hitLed || hitCount))
		|| (pwrite && hitProg && run));
	assign writeOk = access && pwrite && !pslverr;

	assign progWrite = writeOk && hitProg;
	assign progAddr  = paddr[ProgAddrWidth+1:2];
	assign progData  = pwdata[InstrWidth-1:0];
	assign start     = writeOk && hitCtrl && pwdata[0] && !run; // Only on 0 to 1

	// Run bit and halted status
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			run        <= 1'b0;
			haltedFlag <= 1'b0;
		end
		else if (start)
		begin
			run        <= 1'b1;
			haltedFlag <= 1'b0;
		end
		else if (halted)
		begin
			run        <= 1'b0;
			haltedFlag <= 1'b1;
		end
	end

	// Read mux, program words read back as zero
	always_comb
	begin
		prdata = '0;
		if (hitCtrl)
			prdata = ApbDataWidth'(run);
		else if (hitStatus)
			prdata = ApbDataWidth'({haltedFlag, run});
		else if (hitLed)
			prdata = ApbDataWidth'(led);
		else if (hitCount)
			prdata = ApbDataWidth'(retired);
	end

	assert property (@(posedge Clock) disable iff (rst) !(progWrite && run))
		else $error("program write while running");

endmodule

`default_nettype wire

/* logic/miniAluTop.sv */
`default_nettype none

module miniAluTop #(
	parameter int DataWidth     = 16,
	parameter int ProgAddrWidth = 8
) (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [miniAluPkg::ApbAddrWidth-1:0] paddr,
	input  logic [miniAluPkg::ApbDataWidth-1:0] pwdata,
	output logic [miniAluPkg::ApbDataWidth-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic [miniAluPkg::LedWidth-1:0]     led
);
	import miniAluPkg::*;

	// Host side
	logic                     progWrite;
	logic [ProgAddrWidth-1:0] progAddr;
	logic [InstrWidth-1:0]    progData;
	logic                     start;
	logic                     halted;
	logic [DataWidth-1:0]     retired;

	// Pipeline
	logic [InstrWidth-1:0]    instr;
	logic                     instrValid;
	logic [ProgAddrWidth-1:0] returnAddr;
	logic                     redirect;
	logic [ProgAddrWidth-1:0] redirectTarget;
	logic                     halt;

	// Register file
	logic [FieldWidth-1:0]    readAddr0;
	logic [FieldWidth-1:0]    readAddr1;
	logic [DataWidth-1:0]     readData0;
	logic [DataWidth-1:0]     readData1;
	logic                     writeEnable;
	logic [FieldWidth-1:0]    writeAddr;
	logic [DataWidth-1:0]     writeData;

	apbHostPort #(.DataWidth(DataWidth), .ProgAddrWidth(ProgAddrWidth)) hostPort0 (
		.Clock(Clock), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .halted(halted), .led(led), .retired(retired),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .progWrite(progWrite),
		.progAddr(progAddr), .progData(progData), .start(start)
	);

	fetchStage #(.ProgAddrWidth(ProgAddrWidth)) fetch0 (
		.Clock(Clock), .rst(rst), .progWrite(progWrite), .progAddr(progAddr),
		.progData(progData), .start(start), .redirect(redirect),
		.redirectTarget(redirectTarget), .halt(halt), .instr(instr),
		.instrValid(instrValid), .returnAddr(returnAddr)
	);

	executeStage #(.DataWidth(DataWidth), .ProgAddrWidth(ProgAddrWidth)) execute0 (
		.Clock(Clock), .rst(rst), .instr(instr), .instrValid(instrValid),
		.returnAddr(returnAddr), .readData0(readData0), .readData1(readData1),
		.redirect(redirect), .redirectTarget(redirectTarget), .halt(halt),
		.readAddr0(readAddr0), .readAddr1(readAddr1), .writeEnable(writeEnable),
		.writeAddr(writeAddr), .writeData(writeData), .led(led), .halted(halted),
		.retired(retired)
	);

	registerFile #(.DataWidth(DataWidth)) regFile0 (
		.Clock(Clock), .writeEnable(writeEnable), .writeAddr(writeAddr),
		.writeData(writeData), .readAddr0(readAddr0), .readAddr1(readAddr1),
		.readData0(readData0), .readData1(readData1)
	);

endmodule

`default_nettype wire

/* tests/miniAluTb.sv */
`default_nettype none

module miniAluTb;
	timeunit 1ns;
	timeprecision 1ps;
	import miniAluPkg::*;

	localparam int DataWidth      = 16;
	localparam int ProgAddrWidth  = 8;
	localparam int Period         = 40;
	localparam int ResetCycles    = 5;
	localparam int MaxProgWords   = 16;
	localparam int RandomPrograms = 20;
	localparam int NumTests       = 5 + RandomPrograms;
	localparam int WatchdogCycles = ResetCycles + MaxProgWords * 64 * NumTests;

	logic                    Clock;
	logic                    rst;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [ApbAddrWidth-1:0] paddr;
	logic [ApbDataWidth-1:0] pwdata;
	logic [ApbDataWidth-1:0] prdata;
	logic                    pready;
	logic                    pslverr;
	logic [LedWidth-1:0]     ledOut;

	logic [InstrWidth-1:0] prog [2**ProgAddrWidth]; // Program image, mirrors the DUT memory
	int                    progLen;

	miniAluTop #(.DataWidth(DataWidth), .ProgAddrWidth(ProgAddrWidth)) dut0 (
		.Clock(Clock), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .led(ledOut)
	);

	initial
	begin
		Clock = 1'b0;
		forever #(Period / 2) Clock = ~Clock;
	end

	initial
	begin
		#(WatchdogCycles * Period);
		$display("Watchdog expired before all tests finished");
		stopWithFailure();
	end

	task automatic stopWithFailure();
		$display("Test failed");
		$fatal(1);
	endtask

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic checkLed(input string what, input logic [LedWidth-1:0] expected,
		input logic [LedWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h, got 0x%h", what, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkCount(input string what, input logic [DataWidth-1:0] expected,
		input logic [DataWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h, got 0x%h", what, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkStatus(input string what, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h, got 0x%h", what, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkSlverr(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h, got 0x%h", what, expected, actual);
			stopWithFailure();
		end
	endtask

	// ------------------------------------------------------------
	// APB driver
	// ------------------------------------------------------------
	task automatic apbTransfer(input logic write, input logic [ApbAddrWidth-1:0] addr,
		input logic [ApbDataWidth-1:0] wdata, output logic [ApbDataWidth-1:0] rdata,
		output logic err);
		@(negedge Clock);
		psel    = 1'b1; // Setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge Clock);
		penable = 1'b1;
		#(Period / 4); // Middle of the access phase
		if (pready !== 1'b1)
		begin
			$display("pready was low during an access phase");
			stopWithFailure();
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge Clock);
		@(negedge Clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr,
		input logic [ApbDataWidth-1:0] data, output logic err);
		logic [ApbDataWidth-1:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [ApbAddrWidth-1:0] addr,
		output logic [ApbDataWidth-1:0] data, output logic err);
		apbTransfer(1'b0, addr, '0, data, err);
	endtask

	function automatic logic [InstrWidth-1:0] encode(input logic [3:0] op,
		input logic [FieldWidth-1:0] dest, input logic [FieldWidth-1:0] src1,
		input logic [FieldWidth-1:0] src0);
		return {op, dest, src1, src0};
	endfunction

	// Reference interpreter over prog, one entry per executed instruction
	function automatic void runProgram(output logic [LedWidth-1:0] expLed,
		output logic [DataWidth-1:0] expCount);
		logic [DataWidth-1:0]     regs [256];
		logic [ProgAddrWidth-1:0] pc;
		logic [ProgAddrWidth-1:0] nextPc;
		logic [ProgAddrWidth-1:0] retAddr;
		logic [InstrWidth-1:0]    word;
		logic [FieldWidth-1:0]    d;
		logic [FieldWidth-1:0]    s1;
		logic [FieldWidth-1:0]    s0;
		bit                       done;
		pc       = '0;
		retAddr  = '0;
		expLed   = '0;
		expCount = '0;
		done     = 1'b0;
		while (!done && expCount < 10000)
		begin
			word     = prog[pc];
			d        = word[23:16];
			s1       = word[15:8];
			s0       = word[7:0];
			nextPc   = pc + 1'b1;
			expCount = expCount + 1'b1; // Branches and HLT count too
			case (opcodeT'(word[27:24]))
				STO:  regs[d] = DataWidth'({s1, s0});
				ADD:  regs[d] = regs[s1] + regs[s0];
				INC:  regs[d] = regs[s1] + 1'b1;
				BGE:  if (regs[s1] >= regs[s0]) nextPc = d;
				BLE:  if (regs[s1] <= regs[s0]) nextPc = d;
				JMP:  nextPc = d;
				CALL:
				begin
					retAddr = pc + 1'b1;
					nextPc  = d;
				end
				RET:  nextPc = retAddr;
				LED:  expLed = regs[s1][LedWidth-1:0];
				HLT:  done = 1'b1;
				default: ; // Unknown opcode acts as NOP
			endcase
			pc = nextPc;
		end
	endfunction

	// Load prog and set run
	task automatic startProgram();
		logic err;
		for (int i = 0; i < progLen; i++)
		begin
			apbWrite(ProgBase + 12'(4 * i), 32'(prog[i]), err);
			checkSlverr("pslverr on program write", 1'b0, err);
		end
		apbWrite(CtrlOffset, 32'h1, err);
		checkSlverr("pslverr on ctrl write", 1'b0, err);
	endtask

	task automatic waitAndCompare();
		logic                    err;
		logic [ApbDataWidth-1:0] data;
		logic [LedWidth-1:0]     expLed;
		logic [DataWidth-1:0]    expCount;
		int                      polls;
		polls = 0;
		data  = '0;
		while (data[1] !== 1'b1)
		begin
			if (polls == 1000)
			begin
				$display("The program did not halt within 1000 status polls");
				stopWithFailure();
			end
			apbRead(StatusOffset, data, err);
			polls++;
		end
		checkStatus("status", 2'b10, data[1:0]);
		runProgram(expLed, expCount);
		apbRead(LedOffset, data, err);
		checkLed("led register", expLed, data[LedWidth-1:0]);
		checkLed("led port", expLed, ledOut);
		apbRead(CountOffset, data, err);
		checkCount("count", expCount, data[DataWidth-1:0]);
	endtask

	// Straight line, sources only from registers written earlier
	task automatic makeRandomProgram();
		logic [FieldWidth-1:0] written [$];
		logic [FieldWidth-1:0] d;
		int                    body;
		int                    kind;
		body = $urandom_range(3, MaxProgWords - 3);
		d    = 8'($urandom);
		prog[0] = encode(STO, d, 8'($urandom), 8'($urandom));
		written.push_back(d);
		for (int i = 1; i <= body; i++)
		begin
			kind = $urandom_range(0, 2);
			d    = 8'($urandom);
			case (kind)
				0: prog[i] = encode(STO, d, 8'($urandom), 8'($urandom));
				1: prog[i] = encode(ADD, d, written[$urandom_range(0, written.size() - 1)],
					written[$urandom_range(0, written.size() - 1)]);
				default: prog[i] = encode(INC, d,
					written[$urandom_range(0, written.size() - 1)], 8'h00);
			endcase
			written.push_back(d);
		end
		prog[body + 1] = encode(LED, 8'h00, written[$urandom_range(0, written.size() - 1)], 8'h00);
		prog[body + 2] = encode(HLT, 8'h00, 8'h00, 8'h00);
		progLen = body + 3;
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial
	begin
		logic                    err;
		logic [ApbDataWidth-1:0] data;
		void'($urandom(72868));
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		rst = 1'b0;

		// Everything reads zero after reset
		apbRead(CtrlOffset, data, err);
		checkSlverr("pslverr on ctrl read", 1'b0, err);
		checkStatus("ctrl", 2'b00, data[1:0]);
		apbRead(StatusOffset, data, err);
		checkSlverr("pslverr on status read", 1'b0, err);
		checkStatus("status", 2'b00, data[1:0]);
		apbRead(LedOffset, data, err);
		checkSlverr("pslverr on led read", 1'b0, err);
		checkLed("led register", 8'h00, data[LedWidth-1:0]);
		apbRead(CountOffset, data, err);
		checkSlverr("pslverr on count read", 1'b0, err);
		checkCount("count", 16'h0000, data[DataWidth-1:0]);

		// Straight line with one unknown opcode
		prog[0] = encode(STO, 8'd1, 8'h00, 8'h12);
		prog[1] = encode(STO, 8'd2, 8'h00, 8'h34);
		prog[2] = 28'hF000000;
		prog[3] = encode(ADD, 8'd3, 8'd1, 8'd2);
		prog[4] = encode(INC, 8'd4, 8'd3, 8'd0);
		prog[5] = encode(LED, 8'd0, 8'd4, 8'd0);
		prog[6] = encode(HLT, 8'd0, 8'd0, 8'd0);
		progLen = 7;
		startProgram();
		waitAndCompare();

		// Counting loop, BGE at the end falls through
		prog[0] = encode(STO, 8'd10, 8'h00, 8'h00);
		prog[1] = encode(STO, 8'd11, 8'h00, 8'h09);
		prog[2] = encode(STO, 8'd12, 8'h00, 8'h01);
		prog[3] = encode(INC, 8'd10, 8'd10, 8'd0);
		prog[4] = encode(BLE, 8'd3, 8'd10, 8'd11);
		prog[5] = encode(BGE, 8'd0, 8'd12, 8'd11);
		prog[6] = encode(LED, 8'd0, 8'd10, 8'd0);
		prog[7] = encode(HLT, 8'd0, 8'd0, 8'd0);
		progLen = 8;
		startProgram();
		waitAndCompare();

		// Subroutine at 6 called twice
		prog[0] = encode(STO, 8'd20, 8'h00, 8'h05);
		prog[1] = encode(CALL, 8'd6, 8'd0, 8'd0);
		prog[2] = encode(CALL, 8'd6, 8'd0, 8'd0);
		prog[3] = encode(LED, 8'd0, 8'd20, 8'd0);
		prog[4] = encode(HLT, 8'd0, 8'd0, 8'd0);
		prog[5] = encode(NOP, 8'd0, 8'd0, 8'd0);
		prog[6] = encode(INC, 8'd20, 8'd20, 8'd0);
		prog[7] = encode(RET, 8'd0, 8'd0, 8'd0);
		progLen = 8;
		startProgram();
		waitAndCompare();

		// Long loop so the error accesses land while running
		prog[0] = encode(STO, 8'd30, 8'h00, 8'h00);
		prog[1] = encode(STO, 8'd31, 8'h00, 8'd200);
		prog[2] = encode(INC, 8'd30, 8'd30, 8'd0);
		prog[3] = encode(BLE, 8'd2, 8'd30, 8'd31);
		prog[4] = encode(LED, 8'd0, 8'd30, 8'd0);
		prog[5] = encode(HLT, 8'd0, 8'd0, 8'd0);
		progLen = 6;
		startProgram();
		apbRead(12'h010, data, err);
		checkSlverr("pslverr on unmapped read", 1'b1, err);
		apbWrite(12'h010, 32'h1, err);
		checkSlverr("pslverr on unmapped write", 1'b1, err);
		apbWrite(StatusOffset, 32'h3, err);
		checkSlverr("pslverr on status write", 1'b1, err);
		apbWrite(ProgBase + 12'h010, 32'(encode(LED, 8'd0, 8'd31, 8'd0)), err); // Would show 200
		checkSlverr("pslverr on program write while running", 1'b1, err);
		apbRead(CtrlOffset, data, err);
		checkStatus("ctrl", 2'b01, data[1:0]);
		waitAndCompare();
		apbRead(CtrlOffset, data, err);
		checkStatus("ctrl", 2'b00, data[1:0]); // Cleared by HLT

		repeat (RandomPrograms)
		begin
			makeRandomProgram();
			startProgram();
			waitAndCompare();
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/miniAluPkg.sv
logic/registerFile.sv
fetch/fetchStage.sv
execute/executeStage.sv
logic/apbHostPort.sv
logic/miniAluTop.sv
tests/miniAluTb.sv

/* Bender.yml */
package:
  name: minialu

sources:
  - common/miniAluPkg.sv
  - logic/registerFile.sv
  - fetch/fetchStage.sv
  - execute/executeStage.sv
  - logic/apbHostPort.sv
  - logic/miniAluTop.sv
  - target: test
    files:
      - tests/miniAluTb.sv
